/* rv_decode_params.svh */
`ifndef RV_DECODE_PARAMS_SVH
`define RV_DECODE_PARAMS_SVH

// datapath width
`define XLEN 32

// base opcodes, instr[6:0]
`define OP_LOAD   7'b0000011
`define OP_OPIMM  7'b0010011
`define OP_AUIPC  7'b0010111
`define OP_STORE  7'b0100011
`define OP_OP     7'b0110011
`define OP_LUI    7'b0110111
`define OP_BRANCH 7'b1100011
`define OP_JALR   7'b1100111
`define OP_JAL    7'b1101111
`define OP_SYSTEM 7'b1110011

// write back result source
`define FN_ALU    3'd0
`define FN_PC4    3'd1
`define FN_MULDIV 3'd2
`define FN_IMM    3'd3
`define FN_AUIPC  3'd4
`define FN_CSR    3'd6
`define FN_LOAD   3'd7

// immediate format codes
`define IMM_NONE  3'd0
`define IMM_I     3'd1
`define IMM_S     3'd2
`define IMM_B     3'd3
`define IMM_U     3'd4
`define IMM_J     3'd5
`define IMM_SHAMT 3'd6

`endif

/* rv_decode_pkg.sv */
`default_nettype none

package rv_decode_pkg;

	// one fetched word, three ways to slice it
	typedef union packed {
		// register and register-immediate layout
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} ri;

		// store and branch layout
		// immediate split around rs1/rs2
		struct packed {
			logic [6:0] imm_hi;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] imm_lo;
			logic [6:0] opcode;
		} sb;

		// upper immediate and jal layout
		struct packed {
			logic [19:0] imm20;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} uj;
	} rv_instr_t;

endpackage

`default_nettype wire

/* instr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_decode_params.svh"

module instr_decoder import rv_decode_pkg::*; (
	input  rv_instr_t  i_instr,
	// exception waiting at commit
	input  logic       i_exception_pending,
	output logic       o_we,
	output logic       o_csr_we,
	output logic [2:0] o_fn,
	output logic [3:0] o_alu_fn,
	output logic [2:0] o_mul_div_op,
	output logic [3:0] o_mem_op,
	output logic [1:0] o_b_sel,
	output logic [1:0] o_pc_select,
	output logic       o_j,
	output logic       o_jr,
	output logic       o_branch,
	output logic       o_bneq,
	output logic       o_lui,
	output logic       o_auipc,
	output logic       o_ecall,
	output logic       o_mret,
	output logic       o_sret,
	output logic       o_wfi,
	output logic       o_illegal,
	output logic [2:0] o_imm_fmt
);

	// raw fields
	logic [6:0]  opcode;
	logic [2:0]  funct3;
	logic [6:0]  funct7;
	logic [11:0] funct12;
	logic        bit30;

	// instruction classes, one per opcode
	logic is_op, is_opimm, is_load, is_store, is_branch;
	logic is_jal, is_jalr, is_lui, is_auipc, is_system;
	logic bad_opcode;

	// funct7 flavours of OP
	logic f7_base, f7_alt, f7_muldiv, op_legal;

	// shift-immediate forms
	logic opimm_shift;

	// individual branches
	logic i_beq, i_bne, i_blt, i_bge, i_bltu, i_bgeu;

	// loads and stores by width
	logic i_lb, i_lh, i_lw, i_lbu, i_lhu;
	logic i_sb, i_sh, i_sw;

	// privileged SYSTEM forms
	logic sys_priv;

	// branch condition code for the alu
	logic [3:0] br_fn;

	assign opcode  = i_instr.ri.opcode;
	assign funct3  = i_instr.ri.funct3;
	assign funct7  = i_instr.ri.funct7;
	// funct12 overlaps funct7 and rs2
	assign funct12 = {i_instr.ri.funct7, i_instr.ri.rs2};
	assign bit30   = i_instr.ri.funct7[5];

	// class detect
	assign is_op      = (opcode == `OP_OP);
	assign is_opimm   = (opcode == `OP_OPIMM);
	assign is_load    = (opcode == `OP_LOAD);
	assign is_store   = (opcode == `OP_STORE);
	assign is_branch  = (opcode == `OP_BRANCH);
	assign is_jal     = (opcode == `OP_JAL);
	assign is_jalr    = (opcode == `OP_JALR);
	assign is_lui     = (opcode == `OP_LUI);
	assign is_auipc   = (opcode == `OP_AUIPC);
	assign is_system  = (opcode == `OP_SYSTEM);
	// FENCE and compressed fall in here too
	assign bad_opcode = ~(is_op | is_opimm | is_load | is_store | is_branch |
		is_jal | is_jalr | is_lui | is_auipc | is_system);

	// OP accepts base, sub/sra and M-extension funct7 only
	assign f7_base   = (funct7 == 7'b0000000);
	assign f7_alt    = (funct7 == 7'b0100000);
	assign f7_muldiv = (funct7 == 7'b0000001);
	assign op_legal  = f7_base | f7_alt | f7_muldiv;

	// slli 001, srli/srai 101
	assign opimm_shift = is_opimm & ((funct3 == 3'b001) | (funct3 == 3'b101));

	// branch conditions, funct3 010/011 unused
	assign i_beq  = is_branch & (funct3 == 3'b000);
	assign i_bne  = is_branch & (funct3 == 3'b001);
	assign i_blt  = is_branch & (funct3 == 3'b100);
	assign i_bge  = is_branch & (funct3 == 3'b101);
	assign i_bltu = is_branch & (funct3 == 3'b110);
	assign i_bgeu = is_branch & (funct3 == 3'b111);

	// load widths
	assign i_lb  = is_load & (funct3 == 3'b000);
	assign i_lh  = is_load & (funct3 == 3'b001);
	assign i_lw  = is_load & (funct3 == 3'b010);
	assign i_lbu = is_load & (funct3 == 3'b100);
	assign i_lhu = is_load & (funct3 == 3'b101);

	// store widths
	assign i_sb = is_store & (funct3 == 3'b000);
	assign i_sh = is_store & (funct3 == 3'b001);
	assign i_sw = is_store & (funct3 == 3'b010);

	assign sys_priv = is_system & (funct3 == 3'b000);

	// branch compare code
	// beq/bne 1000, blt 0010, bltu 0011, bge 1001, bgeu 1010
	assign br_fn[0] = i_bltu | i_bge;
	assign br_fn[1] = i_blt | i_bltu | i_bgeu;
	assign br_fn[2] = 1'b0;
	assign br_fn[3] = i_beq | i_bne | i_bge | i_bgeu;

	// alu op is {bit30, funct3} for OP
	// OPIMM keeps bit30 only on the right shifts
	assign o_alu_fn = ({4{is_op}} & {bit30, funct3}) |
		({4{is_opimm}} & {bit30 & (funct3 == 3'b101), funct3}) |
		br_fn;

	// M-extension op passes funct3 through
	assign o_mul_div_op = {3{is_op & f7_muldiv}} & funct3;

	// memory op
	// lb 0001 lh 0010 lw 0011 lbu 0100 lhu 0101 sb 1110 sh 1111 sw 1000
	assign o_mem_op[0] = i_lb | i_lw | i_lhu | i_sh;
	assign o_mem_op[1] = i_lh | i_lw | i_sb | i_sh;
	assign o_mem_op[2] = i_lbu | i_lhu | i_sb | i_sh;
	assign o_mem_op[3] = i_sb | i_sh | i_sw;

	// operand b: 01 I-imm, 10 shamt, 00 rs2
	assign o_b_sel[0] = (is_opimm & ~opimm_shift) | is_jalr | is_load;
	assign o_b_sel[1] = opimm_shift;

	// target computed later in execute
	assign o_pc_select = {is_branch | is_jal | is_jalr, 1'b0};

	assign o_j      = is_jal;
	assign o_jr     = is_jalr;
	assign o_branch = is_branch;
	assign o_bneq   = i_bne;
	assign o_lui    = is_lui;
	assign o_auipc  = is_auipc;

	// privileged ops by funct12
	assign o_ecall = sys_priv & (funct12 == 12'h000);
	assign o_mret  = sys_priv & (funct12 == 12'h302);
	assign o_sret  = sys_priv & (funct12 == 12'h102);
	assign o_wfi   = sys_priv & (funct12 == 12'h105);

	assign o_illegal = bad_opcode | (is_op & ~op_legal);

	// no write back for illegal words
	// pending exception only blocks SYSTEM
	assign o_we = (is_op & op_legal) | is_opimm | is_jal | is_jalr | is_load |
		is_lui | is_auipc | (is_system & ~i_exception_pending);

	// csrrw and friends, not ecall/mret
	assign o_csr_we = is_system & (|funct3);

	// result source
	always_comb begin
		o_fn = `FN_ALU;
		if (is_jal | is_jalr)
			o_fn = `FN_PC4;
		else if (is_op & f7_muldiv)
			o_fn = `FN_MULDIV;
		else if (is_lui)
			o_fn = `FN_IMM;
		else if (is_auipc)
			o_fn = `FN_AUIPC;
		else if (is_system)
			o_fn = `FN_CSR;
		else if (is_load)
			o_fn = `FN_LOAD;
	end

	// immediate layout per class
	always_comb begin
		o_imm_fmt = `IMM_NONE;
		if (opimm_shift)
			o_imm_fmt = `IMM_SHAMT;
		// csr address sits in the I field
		else if (is_opimm | is_load | is_jalr | is_system)
			o_imm_fmt = `IMM_I;
		else if (is_store)
			o_imm_fmt = `IMM_S;
		else if (is_branch)
			o_imm_fmt = `IMM_B;
		else if (is_lui | is_auipc)
			o_imm_fmt = `IMM_U;
		else if (is_jal)
			o_imm_fmt = `IMM_J;
	end

	// operand b choice and immediate layout must agree
	a_bsel_fmt: assert property (@(i_instr)
		(o_b_sel != 2'b00) |-> (o_imm_fmt == (o_b_sel[1] ? `IMM_SHAMT : `IMM_I)));

endmodule

`default_nettype wire

/* imm_gen.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_decode_params.svh"

module imm_gen import rv_decode_pkg::*; (
	input  rv_instr_t         i_instr,
	output logic [`XLEN-1:0]  o_imm_i,
	output logic [`XLEN-1:0]  o_imm_s,
	output logic [`XLEN-1:0]  o_imm_b,
	output logic [`XLEN-1:0]  o_imm_u,
	output logic [`XLEN-1:0]  o_imm_j,
	output logic [4:0]        o_shamt
);

	// sign bit, always instr[31]
	logic       sign;
	// S/B fields
	logic [6:0] hi;
	logic [4:0] lo;
	// U/J field, instr[31:12]
	logic [19:0] up;

	assign sign = i_instr.ri.funct7[6];
	assign hi   = i_instr.sb.imm_hi;
	assign lo   = i_instr.sb.imm_lo;
	assign up   = i_instr.uj.imm20;

	// I: instr[31:20]
	assign o_imm_i = {{(`XLEN-12){sign}}, i_instr.ri.funct7, i_instr.ri.rs2};

	// S: instr[31:25] then instr[11:7]
	assign o_imm_s = {{(`XLEN-12){sign}}, hi, lo};

	// B: imm[12|10:5] in hi, imm[4:1|11] in lo
	// lsb is always zero
	assign o_imm_b = {
		{(`XLEN-12){sign}},
		lo[0],
		hi[5:0],
		lo[4:1],
		1'b0
	};

	// U: upper 20 bits, low 12 cleared
	assign o_imm_u = {up, {(`XLEN-20){1'b0}}};

	// J: instr[31] imm[20], [30:21] imm[10:1]
	// instr[20] imm[11], [19:12] imm[19:12]
	assign o_imm_j = {
		{(`XLEN-20){sign}},
		up[7:0],
		up[8],
		up[18:9],
		1'b0
	};

	// shift amount lives where rs2 would be
	assign o_shamt = i_instr.ri.rs2;

endmodule

`default_nettype wire

/* decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_decode_params.svh"

module decode_stage import rv_decode_pkg::*; (
	input  logic              i_clk,
	input  logic              i_reset,
	input  logic              i_valid,
	input  rv_instr_t         i_instr,
	input  logic              i_exception_pending,
	output logic              o_valid,
	output logic [`XLEN-1:0]  o_imm,
	output logic              o_we,
	output logic              o_csr_we,
	output logic [2:0]        o_fn,
	output logic [3:0]        o_alu_fn,
	output logic [2:0]        o_mul_div_op,
	output logic [3:0]        o_mem_op,
	output logic [1:0]        o_b_sel,
	output logic [1:0]        o_pc_select,
	output logic              o_j,
	output logic              o_jr,
	output logic              o_branch,
	output logic              o_bneq,
	output logic              o_lui,
	output logic              o_auipc,
	output logic              o_ecall,
	output logic              o_mret,
	output logic              o_sret,
	output logic              o_wfi,
	output logic              o_illegal
);

	// decoder outputs, combinational
	logic             dec_we, dec_csr_we;
	logic [2:0]       dec_fn, dec_mul_div_op, dec_imm_fmt;
	logic [3:0]       dec_alu_fn, dec_mem_op;
	logic [1:0]       dec_b_sel, dec_pc_select;
	logic             dec_j, dec_jr, dec_branch, dec_bneq;
	logic             dec_lui, dec_auipc, dec_illegal;
	logic             dec_ecall, dec_mret, dec_sret, dec_wfi;

	// immediate candidates
	logic [`XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j, imm_sel;
	logic [4:0]       shamt;

	instr_decoder u_instr_decoder (
		.i_instr             (i_instr),
		.i_exception_pending (i_exception_pending),
		.o_we                (dec_we),
		.o_csr_we            (dec_csr_we),
		.o_fn                (dec_fn),
		.o_alu_fn            (dec_alu_fn),
		.o_mul_div_op        (dec_mul_div_op),
		.o_mem_op            (dec_mem_op),
		.o_b_sel             (dec_b_sel),
		.o_pc_select         (dec_pc_select),
		.o_j                 (dec_j),
		.o_jr                (dec_jr),
		.o_branch            (dec_branch),
		.o_bneq              (dec_bneq),
		.o_lui               (dec_lui),
		.o_auipc             (dec_auipc),
		.o_ecall             (dec_ecall),
		.o_mret              (dec_mret),
		.o_sret              (dec_sret),
		.o_wfi               (dec_wfi),
		.o_illegal           (dec_illegal),
		.o_imm_fmt           (dec_imm_fmt)
	);

	imm_gen u_imm_gen (
		.i_instr (i_instr),
		.o_imm_i (imm_i),
		.o_imm_s (imm_s),
		.o_imm_b (imm_b),
		.o_imm_u (imm_u),
		.o_imm_j (imm_j),
		.o_shamt (shamt)
	);

	// pick immediate by format
	always_comb begin
		case (dec_imm_fmt)
			`IMM_I:     imm_sel = imm_i;
			`IMM_S:     imm_sel = imm_s;
			`IMM_B:     imm_sel = imm_b;
			`IMM_U:     imm_sel = imm_u;
			`IMM_J:     imm_sel = imm_j;
			// shamt zero-extended
			`IMM_SHAMT: imm_sel = {{(`XLEN-5){1'b0}}, shamt};
			default:    imm_sel = '0;
		endcase
	end

	// control group
	// valid and write enables drop between strobes
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			o_valid   <= 1'b0;
			o_we      <= 1'b0;
			o_csr_we  <= 1'b0;
			o_j       <= 1'b0;
			o_jr      <= 1'b0;
			o_branch  <= 1'b0;
			o_illegal <= 1'b0;
			o_mem_op  <= 4'b0000;
		end else begin
			o_valid  <= i_valid;
			o_we     <= i_valid & dec_we;
			o_csr_we <= i_valid & dec_csr_we;
			// these hold across gaps
			if (i_valid) begin
				o_j       <= dec_j;
				o_jr      <= dec_jr;
				o_branch  <= dec_branch;
				o_illegal <= dec_illegal;
				o_mem_op  <= dec_mem_op;
			end
		end
	end

	// payload, loaded on strobe only
	always_ff @(posedge i_clk) begin
		if (i_valid) begin
			o_imm        <= imm_sel;
			o_fn         <= dec_fn;
			o_alu_fn     <= dec_alu_fn;
			o_mul_div_op <= dec_mul_div_op;
			o_b_sel      <= dec_b_sel;
			o_pc_select  <= dec_pc_select;
			o_bneq       <= dec_bneq;
			o_lui        <= dec_lui;
			o_auipc      <= dec_auipc;
			o_ecall      <= dec_ecall;
			o_mret       <= dec_mret;
			o_sret       <= dec_sret;
			o_wfi        <= dec_wfi;
		end
	end

	// a shift operand beat carries only the 5-bit shamt
	a_shamt_zero_ext: assert property (@(posedge i_clk) disable iff (i_reset)
		(o_valid && o_b_sel == 2'b10) |-> (o_imm[`XLEN-1:5] == '0));

	// illegal words never reach write back
	a_no_we_on_illegal: assert property (@(posedge i_clk) disable iff (i_reset)
		!(o_we && o_illegal));

endmodule

`default_nettype wire

/* tb_decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_decode_params.svh"

module tb_decode_stage;

	logic              i_clk;
	logic              i_reset;
	logic              i_valid;
	logic [31:0]       i_instr;
	logic              i_exception_pending;
	logic              o_valid, o_we, o_csr_we;
	logic [`XLEN-1:0]  o_imm;
	logic [2:0]        o_fn, o_mul_div_op;
	logic [3:0]        o_alu_fn, o_mem_op;
	logic [1:0]        o_b_sel, o_pc_select;
	logic              o_j, o_jr, o_branch, o_bneq, o_lui, o_auipc;
	logic              o_ecall, o_mret, o_sret, o_wfi, o_illegal;

	// expected bundle, loaded at the strobe edge
	logic              exp_valid, exp_we, exp_csr_we;
	logic [28:0]       exp_ctrl;
	logic [31:0]       exp_imm;
	logic [28:0]       ctrl_now;
	integer            seed;
	int                pass_count, err_count, err_at_start;
	string             test_name;
	logic [31:0]       w;

	decode_stage dut (.*);

	assign ctrl_now = {o_fn, o_alu_fn, o_mul_div_op, o_mem_op, o_b_sel, o_pc_select, o_j, o_jr,
		o_branch, o_bneq, o_lui, o_auipc, o_ecall, o_mret, o_sret, o_wfi, o_illegal};

	initial begin
		i_clk = 1'b0;
		forever #50 i_clk = ~i_clk;
	end

	// control fields straight from the RISC-V encodings
	function automatic logic [28:0] ref_ctrl(input logic [31:0] iw);
		logic [6:0] op;
		logic [2:0] f3;
		logic [11:0] f12;
		logic sys0;
		logic illegal;
		logic [2:0] fn;
		logic [3:0] alu;
		logic [3:0] mem;
		logic [1:0] bsel;
		op = iw[6:0];
		f3 = iw[14:12];
		f12 = iw[31:20];
		sys0 = (op == `OP_SYSTEM) && (f3 == 3'b000);
		illegal = !(op inside {`OP_LOAD, `OP_OPIMM, `OP_AUIPC, `OP_STORE, `OP_OP, `OP_LUI,
			`OP_BRANCH, `OP_JALR, `OP_JAL, `OP_SYSTEM}) ||
			((op == `OP_OP) && !(iw[31:25] inside {7'h00, 7'h20, 7'h01}));
		alu = 4'b0000;
		if (op == `OP_OP)
			alu = {iw[30], f3};
		else if (op == `OP_OPIMM)
			alu = {iw[30] && (f3 == 3'b101), f3};
		else if (op == `OP_BRANCH)
			case (f3)
				3'b000, 3'b001: alu = 4'b1000;
				3'b100: alu = 4'b0010;
				3'b110: alu = 4'b0011;
				3'b101: alu = 4'b1001;
				3'b111: alu = 4'b1010;
				default: alu = 4'b0000;
			endcase
		// load widths count up, stores sit at the top
		mem = 4'b0000;
		if (op == `OP_LOAD && f3 inside {3'b000, 3'b001, 3'b010})
			mem = {1'b0, f3} + 4'd1;
		else if (op == `OP_LOAD && f3 inside {3'b100, 3'b101})
			mem = {1'b0, f3};
		else if (op == `OP_STORE && f3 == 3'b000)
			mem = 4'b1110;
		else if (op == `OP_STORE && f3 == 3'b001)
			mem = 4'b1111;
		else if (op == `OP_STORE && f3 == 3'b010)
			mem = 4'b1000;
		bsel = 2'b00;
		if (op == `OP_OPIMM)
			bsel = (f3 == 3'b001 || f3 == 3'b101) ? 2'b10 : 2'b01;
		else if (op == `OP_JALR || op == `OP_LOAD)
			bsel = 2'b01;
		fn = `FN_ALU;
		if (op == `OP_JAL || op == `OP_JALR)
			fn = `FN_PC4;
		else if (op == `OP_OP && iw[31:25] == 7'b0000001)
			fn = `FN_MULDIV;
		else if (op == `OP_LUI)
			fn = `FN_IMM;
		else if (op == `OP_AUIPC)
			fn = `FN_AUIPC;
		else if (op == `OP_SYSTEM)
			fn = `FN_CSR;
		else if (op == `OP_LOAD)
			fn = `FN_LOAD;
		return {fn, alu, (op == `OP_OP && iw[31:25] == 7'b0000001) ? f3 : 3'b000, mem, bsel,
			(op == `OP_BRANCH || op == `OP_JAL || op == `OP_JALR) ? 2'b10 : 2'b00,
			op == `OP_JAL, op == `OP_JALR, op == `OP_BRANCH,
			op == `OP_BRANCH && f3 == 3'b001, op == `OP_LUI, op == `OP_AUIPC,
			sys0 && f12 == 12'h000, sys0 && f12 == 12'h302, sys0 && f12 == 12'h102,
			sys0 && f12 == 12'h105, illegal};
	endfunction

	// {we, csr_we}; illegal words never write
	function automatic logic [1:0] ref_we(input logic [31:0] iw, input logic exc);
		logic [6:0] op;
		logic we;
		op = iw[6:0];
		we = op inside {`OP_OPIMM, `OP_JAL, `OP_JALR, `OP_LOAD, `OP_LUI, `OP_AUIPC} ||
			(op == `OP_OP && iw[31:25] inside {7'h00, 7'h20, 7'h01}) ||
			(op == `OP_SYSTEM && !exc);
		return {we, op == `OP_SYSTEM && iw[14:12] != 3'b000};
	endfunction

	function automatic logic [31:0] ref_imm(input logic [31:0] iw);
		case (iw[6:0])
			`OP_OPIMM:
				if (iw[14:12] == 3'b001 || iw[14:12] == 3'b101)
					return {27'd0, iw[24:20]};
				else
					return {{20{iw[31]}}, iw[31:20]};
			// csr address travels as an I immediate
			`OP_LOAD, `OP_JALR, `OP_SYSTEM: return {{20{iw[31]}}, iw[31:20]};
			`OP_STORE: return {{20{iw[31]}}, iw[31:25], iw[11:7]};
			`OP_BRANCH: return {{19{iw[31]}}, iw[31], iw[7], iw[30:25], iw[11:8], 1'b0};
			`OP_LUI, `OP_AUIPC: return {iw[31:12], 12'd0};
			`OP_JAL: return {{11{iw[31]}}, iw[31], iw[19:12], iw[20], iw[30:21], 1'b0};
			default: return 32'd0;
		endcase
	endfunction

	always @(posedge i_clk) begin
		if (i_reset) begin
			exp_valid <= 1'b0;
			exp_we <= 1'b0;
			exp_csr_we <= 1'b0;
		end else begin
			exp_valid <= i_valid;
			{exp_we, exp_csr_we} <= i_valid ? ref_we(i_instr, i_exception_pending) : 2'b00;
			if (i_valid) begin
				exp_ctrl <= ref_ctrl(i_instr);
				exp_imm <= ref_imm(i_instr);
			end
		end
	end

	// o_valid exactly one cycle after each strobe
	a_strobe: assert property (@(posedge i_clk) disable iff (i_reset) o_valid == exp_valid)
		pass_count++;
	else begin
		err_count++;
		$display("ERROR %s: o_valid expected %b actual %b", test_name,
			$sampled(exp_valid), $sampled(o_valid));
	end

	// write enables also drop in gaps
	a_write: assert property (@(posedge i_clk) disable iff (i_reset)
		{o_we, o_csr_we} == {exp_we, exp_csr_we})
		pass_count++;
	else begin
		err_count++;
		$display("ERROR %s: we/csr_we expected %b%b actual %b%b", test_name,
			$sampled(exp_we), $sampled(exp_csr_we), $sampled(o_we), $sampled(o_csr_we));
	end

	a_ctrl: assert property (@(posedge i_clk) disable iff (i_reset)
		exp_valid |-> ctrl_now == exp_ctrl)
		pass_count++;
	else begin
		err_count++;
		$display("ERROR %s: control expected %h actual %h", test_name,
			$sampled(exp_ctrl), $sampled(ctrl_now));
	end

	a_imm: assert property (@(posedge i_clk) disable iff (i_reset)
		exp_valid |-> o_imm == exp_imm)
		pass_count++;
	else begin
		err_count++;
		$display("ERROR %s: o_imm expected %h actual %h", test_name,
			$sampled(exp_imm), $sampled(o_imm));
	end

	// bounded wait for the output beat
	task automatic wait_output();
		int n;
		n = 0;
		while (!o_valid && n < 10) begin
			@(posedge i_clk);
			#1;
			n++;
		end
		if (!o_valid) begin
			$display("timeout: o_valid never rose in test %s", test_name);
			$display("TESTBENCH FAILED");
			$finish;
		end
	endtask

	// one strobe, then a gap cycle
	task automatic send_word(input logic [31:0] iw, input logic exc);
		i_instr = iw;
		i_exception_pending = exc;
		i_valid = 1'b1;
		@(posedge i_clk);
		#1;
		i_valid = 1'b0;
		wait_output();
		@(posedge i_clk);
		#1;
	endtask

	// random word with opcode, funct3 and funct7 forced
	task automatic send_fields(input logic [6:0] op, input logic [2:0] f3,
		input logic [6:0] f7);
		logic [31:0] word;
		word = $random(seed);
		word[6:0] = op;
		word[14:12] = f3;
		word[31:25] = f7;
		send_word(word, 1'b0);
	endtask

	task automatic start_test(input string name);
		test_name = name;
		err_at_start = err_count;
	endtask

	task automatic end_test();
		$display("test %s finished, %0d errors", test_name, err_count - err_at_start);
	endtask

	initial begin
		seed = 55115;
		pass_count = 0;
		err_count = 0;
		test_name = "reset";
		i_reset = 1'b1;
		i_valid = 1'b0;
		i_instr = 32'd0;
		i_exception_pending = 1'b0;
		repeat (10) @(posedge i_clk);
		#1;
		i_reset = 1'b0;
		repeat (2) @(posedge i_clk);
		#1;

		start_test("reset_strobe");
		send_fields(`OP_OPIMM, 3'b000, 7'h00);
		// back-to-back burst
		for (int i = 0; i < 4; i++) begin
			w = $random(seed);
			w[6:0] = i[0] ? `OP_LUI : `OP_OPIMM;
			i_instr = w;
			i_valid = 1'b1;
			@(posedge i_clk);
			#1;
		end
		i_valid = 1'b0;
		wait_output();
		repeat (2) @(posedge i_clk);
		#1;
		end_test();

		start_test("alu_ops");
		for (int i = 0; i < 16; i++) begin
			w = $random(seed);
			send_fields(`OP_OP, w[2:0], w[3] ? 7'h20 : 7'h00);
			send_fields(`OP_OPIMM, w[6:4], w[7] ? 7'h20 : 7'h00);
		end
		end_test();

		start_test("mul_div");
		for (int f = 0; f < 8; f++)
			send_fields(`OP_OP, f[2:0], 7'h01);
		// funct7 values OP leaves undefined
		send_fields(`OP_OP, 3'b000, 7'h02);
		send_fields(`OP_OP, 3'b101, 7'h21);
		send_fields(`OP_OP, 3'b100, 7'h7f);
		end_test();

		start_test("load_store");
		for (int f = 0; f < 8; f++) begin
			w = $random(seed);
			send_fields(`OP_LOAD, f[2:0], w[6:0]);
			send_fields(`OP_STORE, f[2:0], w[13:7]);
		end
		end_test();

		start_test("branch_jump");
		for (int f = 0; f < 8; f++) begin
			w = $random(seed);
			send_fields(`OP_BRANCH, f[2:0], w[6:0]);
			send_fields(`OP_JAL, w[9:7], w[16:10]);
			send_fields(`OP_JALR, 3'b000, w[23:17]);
		end
		end_test();

		start_test("upper_system");
		for (int i = 0; i < 4; i++) begin
			w = $random(seed);
			send_fields(`OP_LUI, w[2:0], w[9:3]);
			send_fields(`OP_AUIPC, w[12:10], w[19:13]);
		end
		// ecall, mret, sret, wfi with and without a pending exception
		for (int e = 0; e < 2; e++) begin
			send_word({12'h000, 13'd0, `OP_SYSTEM}, e[0]);
			send_word({12'h302, 13'd0, `OP_SYSTEM}, e[0]);
			send_word({12'h102, 13'd0, `OP_SYSTEM}, e[0]);
			send_word({12'h105, 13'd0, `OP_SYSTEM}, e[0]);
			send_fields(`OP_SYSTEM, 3'b001, 7'h18);
		end
		for (int i = 0; i < 8; i++) begin
			w = $random(seed);
			while (w[6:0] inside {`OP_LOAD, `OP_OPIMM, `OP_AUIPC, `OP_STORE, `OP_OP,
				`OP_LUI, `OP_BRANCH, `OP_JALR, `OP_JAL, `OP_SYSTEM})
				w[6:0] = w[6:0] + 7'd1;
			send_word(w, 1'b0);
		end
		end_test();

		$display("checks passed: %0d, errors: %0d", pass_count, err_count);
		if (err_count == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
+incdir+.
rv_decode_pkg.sv
instr_decoder.sv
imm_gen.sv
decode_stage.sv
tb_decode_stage.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_decode_stage
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f files.f --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
